// File: design/dp_params.svh
`ifndef DP_PARAMS_SVH
`define DP_PARAMS_SVH

// Datapath word width
// Also the default width of every bus switch
`define DATA_WIDTH 8

// Number of general registers
`define NUM_REGS 4

// Instruction field widths
// Opcode on top, then rd and rs indices, then the immediate
`define OP_WIDTH 4
`define IMM_WIDTH 8

// Register index width follows from NUM_REGS
// Instruction is OP_WIDTH + 2 * index + IMM_WIDTH bits
// Four registers give a 16 bit word

`endif

// File: design/dp_pkg.sv
package dp_pkg;
	`include "dp_params.svh"

	// One data word
	typedef logic [`DATA_WIDTH-1:0] data_t;
	// Register index
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
	// Opcode field
	typedef logic [`OP_WIDTH-1:0] opcode_t;

	// Opcodes 8 to 15 behave as NOP
	localparam opcode_t OP_NOP = 4'd0;
	localparam opcode_t OP_LDI = 4'd1;
	localparam opcode_t OP_MOV = 4'd2;
	localparam opcode_t OP_ADD = 4'd3;
	localparam opcode_t OP_SUB = 4'd4;
	localparam opcode_t OP_AND = 4'd5;
	localparam opcode_t OP_OR  = 4'd6;
	localparam opcode_t OP_XOR = 4'd7;

	// 16 bit instruction word, opcode in the top bits
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		logic [`IMM_WIDTH-1:0] imm;
	} instr_t;

	// Decode stage register
	typedef struct packed {
		logic valid;
		opcode_t opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		logic [`IMM_WIDTH-1:0] imm;
	} dec_t;

	// Execute and result stage register
	// Also the bypass source
	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		data_t data;
	} wb_t;

	// Register 0 in the lowest bits
	typedef data_t [`NUM_REGS-1:0] regfile_t;
endpackage

// File: design/bus_switch.sv
`include "dp_params.svh"

// N to 1 word switch
// Behaves like a case statement on sel
// Word k sits at data_in[k*DATA_WIDTH +: DATA_WIDTH]
module bus_switch #(
	parameter int DATA_WIDTH = `DATA_WIDTH,
	// Power of two, 2 or more
	parameter int SIZE = 2
) (
	input logic [SIZE*DATA_WIDTH-1:0] data_in,
	input logic [$clog2(SIZE)-1:0] sel,
	output logic [DATA_WIDTH-1:0] data_out
);
	localparam int SEL_WIDTH = $clog2(SIZE);

	generate
		if (SIZE == 2) begin : g_leaf
			// Last level is one two input stage
			bus_switch_2x1 #(.DATA_WIDTH(DATA_WIDTH)) stage0_i (
				.data_in(data_in),
				.sel(sel[SEL_WIDTH-1]),
				.data_out(data_out)
			);
		end else begin : g_split
			localparam int HALF = SIZE / 2;
			logic [DATA_WIDTH-1:0] upper_out;
			logic [DATA_WIDTH-1:0] lower_out;

			// Upper half of the words
			bus_switch #(.DATA_WIDTH(DATA_WIDTH), .SIZE(HALF)) upper_i (
				.data_in(data_in[SIZE*DATA_WIDTH-1:HALF*DATA_WIDTH]),
				.sel(sel[SEL_WIDTH-2:0]),
				.data_out(upper_out)
			);

			// Lower half of the words
			bus_switch #(.DATA_WIDTH(DATA_WIDTH), .SIZE(HALF)) lower_i (
				.data_in(data_in[HALF*DATA_WIDTH-1:0]),
				.sel(sel[SEL_WIDTH-2:0]),
				.data_out(lower_out)
			);

			// Top select bit picks the half
			bus_switch_2x1 #(.DATA_WIDTH(DATA_WIDTH)) stage0_i (
				.data_in({upper_out, lower_out}),
				.sel(sel[SEL_WIDTH-1]),
				.data_out(data_out)
			);
		end
	endgenerate
endmodule

// Two input switch stage
// One AND-OR gate mux per bit
module bus_switch_2x1 #(
	parameter int DATA_WIDTH = `DATA_WIDTH
) (
	input logic [2*DATA_WIDTH-1:0] data_in,
	input logic sel,
	output logic [DATA_WIDTH-1:0] data_out
);
	genvar i;
	generate
		for (i = 0; i < DATA_WIDTH; i++) begin : g_bit
			logic hi_term;
			logic lo_term;

			// sel high passes the upper word
			assign hi_term = data_in[DATA_WIDTH+i] & sel;
			assign lo_term = data_in[i] & ~sel;
			assign data_out[i] = hi_term | lo_term;
		end
	endgenerate
endmodule

// File: design/instr_decode.sv
// Decode stage
// Registers the strobe together with the instruction fields
module instr_decode
	import dp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input instr_t instr,
	output dec_t dec
);
	logic op_known;

	// Only LDI through XOR write a register
	// NOP and opcodes 8 to 15 drop out here
	always_comb begin
		op_known = 1'b0;
		if (instr.opcode inside {[OP_LDI:OP_XOR]}) begin
			op_known = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		// Fields follow the strobe
		if (instr_valid) begin
			dec.opcode <= instr.opcode;
			dec.rd <= instr.rd;
			dec.rs <= instr.rs;
			dec.imm <= instr.imm;
		end

		// Valid is the only control bit
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			// Later stages never look at the opcode range
			dec.valid <= instr_valid & op_known;
		end
	end
endmodule

// File: design/alu_execute.sv
`include "dp_params.svh"

// Execute stage
// Operand read, forwarding, ALU and result select
module alu_execute
	import dp_pkg::*;
(
	input logic clk,
	input logic rst,
	input dec_t dec,
	input wb_t wb,
	input regfile_t regs,
	output wb_t exe
);
	// One result slot per low opcode value
	localparam int RES_SIZE = 8;

	data_t rd_reg;
	data_t rs_reg;
	data_t rd_val;
	data_t rs_val;
	data_t sum;
	data_t diff;
	data_t res;

	// Register file read ports
	bus_switch #(.DATA_WIDTH($bits(data_t)), .SIZE(`NUM_REGS)) rd_read_i (
		.data_in(regs),
		.sel(dec.rd),
		.data_out(rd_reg)
	);

	bus_switch #(.DATA_WIDTH($bits(data_t)), .SIZE(`NUM_REGS)) rs_read_i (
		.data_in(regs),
		.sel(dec.rs),
		.data_out(rs_reg)
	);

	// Forwarding
	// Newest value wins, so exe comes before wb
	always_comb begin
		rd_val = rd_reg;
		rs_val = rs_reg;
		if (exe.valid && exe.rd == dec.rd) begin
			rd_val = exe.data;
		end else if (wb.valid && wb.rd == dec.rd) begin
			rd_val = wb.data;
		end
		if (exe.valid && exe.rd == dec.rs) begin
			rs_val = exe.data;
		end else if (wb.valid && wb.rd == dec.rs) begin
			rs_val = wb.data;
		end
	end

	// Wraps modulo 256
	assign sum = rd_val + rs_val;
	assign diff = rd_val - rs_val;

	// Result select by low opcode bits
	// Slot 0 is NOP and never reaches exe
	bus_switch #(.DATA_WIDTH($bits(data_t)), .SIZE(RES_SIZE)) res_sel_i (
		.data_in({rd_val ^ rs_val, rd_val | rs_val, rd_val & rs_val,
			diff, sum, rs_val, data_t'(dec.imm), data_t'(0)}),
		.sel(dec.opcode[$clog2(RES_SIZE)-1:0]),
		.data_out(res)
	);

	always_ff @(posedge clk) begin
		if (dec.valid) begin
			exe.rd <= dec.rd;
			exe.data <= res;
		end
		if (rst) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= dec.valid;
		end
	end
endmodule

// File: design/reg_result.sv
// Result stage
// Holds the register file and reports each write
module reg_result
	import dp_pkg::*;
(
	input logic clk,
	input logic rst,
	input wb_t exe,
	output wb_t wb,
	output regfile_t regs,
	output logic result_valid,
	output reg_idx_t result_reg,
	output data_t result_data
);
	// Result register
	// Loads on the same edge as the register write
	always_ff @(posedge clk) begin
		if (exe.valid) begin
			wb.rd <= exe.rd;
			wb.data <= exe.data;
		end
		if (rst) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= exe.valid;
		end
	end

	// Register file write port
	// All registers start at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '0;
		end else if (exe.valid) begin
			regs[exe.rd] <= exe.data;
		end
	end

	// One pulse per write
	assign result_valid = wb.valid;
	assign result_reg = wb.rd;
	// Same value just stored in regs
	assign result_data = wb.data;
endmodule

// File: design/dp_top.sv
// Three stage register file datapath
// Decode, execute, result
module dp_top
	import dp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input instr_t instr,
	output logic result_valid,
	output reg_idx_t result_reg,
	output data_t result_data
);
	dec_t dec;
	wb_t exe;
	wb_t wb;
	regfile_t regs;

	instr_decode decode_i (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.dec(dec)
	);

	// Reads regs and forwards from exe and wb
	alu_execute execute_i (
		.clk(clk),
		.rst(rst),
		.dec(dec),
		.wb(wb),
		.regs(regs),
		.exe(exe)
	);

	reg_result result_i (
		.clk(clk),
		.rst(rst),
		.exe(exe),
		.wb(wb),
		.regs(regs),
		.result_valid(result_valid),
		.result_reg(result_reg),
		.result_data(result_data)
	);
endmodule

// File: bench/dp_properties.sv
// Port level checks on dp_top
// Attached to every dp_top by the bind below
module dp_properties
	import dp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input instr_t instr,
	input logic result_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic writes_reg;
	logic seen_instr;

	// Strobe with an opcode that writes
	assign writes_reg = instr_valid && instr.opcode >= OP_LDI && instr.opcode <= OP_XOR;

	// Set by the first accepted instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			seen_instr <= 1'b0;
		end else if (instr_valid) begin
			seen_instr <= 1'b1;
		end
	end

	// Quiet output until something was accepted
	quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		!seen_instr |-> !result_valid)
		else $error("result_valid high before any instruction was accepted");

	// Fixed latency of three edges
	// No writes lost or made up
	latency_three: assert property (@(posedge clk) disable iff (rst)
		result_valid == $past(writes_reg, 3))
		else $error("result_valid does not follow a writing instruction by three edges");
endmodule

bind dp_top dp_properties props_i (
	.clk(clk),
	.rst(rst),
	.instr_valid(instr_valid),
	.instr(instr),
	.result_valid(result_valid)
);

// File: bench/dp_tb.sv
`include "dp_params.svh"

// Testbench for the three stage datapath
// Instructions and expected writes come from the stimulus file
module dp_tb
	import dp_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Five hex words per stimulus line
	localparam int REC_WORDS = 5;
	localparam int MAX_RECS = 128;
	// Edges allowed for the pipeline to empty
	localparam int DRAIN_LIMIT = 40;
	// Idle edges after the drain so a stray result still shows up
	localparam int QUIET_EDGES = 8;
	// Flag column value that ends the stream
	localparam logic [3:0] END_FLAG = 4'hf;

	// One line of the stimulus file
	typedef struct packed {
		instr_t instr;
		logic [7:0] gap;
		logic [3:0] flag;
		reg_idx_t rd;
		data_t data;
	} stim_rec_t;

	// One expected register write
	typedef struct packed {
		reg_idx_t rd;
		data_t data;
	} write_t;

	logic clk;
	logic rst;
	logic instr_valid;
	instr_t instr;
	logic result_valid;
	reg_idx_t result_reg;
	data_t result_data;

	// Raw file contents
	logic [15:0] stim_mem [0:REC_WORDS*MAX_RECS-1];
	// Writes still in flight
	// Oldest first
	write_t exp_q[$];
	// Sequential model of the register file
	data_t model_regs [0:`NUM_REGS-1];
	int write_count;

	dp_top dut_i (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.result_valid(result_valid),
		.result_reg(result_reg),
		.result_data(result_data)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Ends the run on any failure
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// Compares one value against its expectation
	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		string line;
		if (got !== exp) begin
			line = $sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			fail_run(line);
		end
	endtask

	// Unpacks line n of the file
	function automatic stim_rec_t read_record(input int n);
		stim_rec_t rec;
		int base;
		base = n * REC_WORDS;
		rec.instr = stim_mem[base];
		rec.gap = stim_mem[base+1][7:0];
		rec.flag = stim_mem[base+2][3:0];
		rec.rd = stim_mem[base+3][1:0];
		rec.data = stim_mem[base+4][7:0];
		return rec;
	endfunction

	// Reference model of one instruction
	// Returns 1 when the instruction writes a register
	function automatic bit predict(input instr_t ins, output write_t wr);
		data_t a;
		data_t b;
		bit writes;
		a = model_regs[ins.rd];
		b = model_regs[ins.rs];
		writes = 1'b1;
		wr.rd = ins.rd;
		wr.data = '0;
		case (ins.opcode)
			OP_LDI: wr.data = ins.imm;
			OP_MOV: wr.data = b;
			// Eight bit result so both wrap modulo 256
			OP_ADD: wr.data = a + b;
			OP_SUB: wr.data = a - b;
			OP_AND: wr.data = a & b;
			OP_OR: wr.data = a | b;
			OP_XOR: wr.data = a ^ b;
			// NOP and opcodes 8 to 15
			default: writes = 1'b0;
		endcase
		if (writes) begin
			model_regs[ins.rd] = wr.data;
		end
		return writes;
	endfunction

	// Idle gap, then one instruction strobe
	task automatic drive_record(input stim_rec_t rec);
		write_t wr;
		bit writes;
		repeat (rec.gap) begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= rec.instr;
		// File columns must agree with the model
		writes = predict(rec.instr, wr);
		check_value("stim_flag", 16'(rec.flag), 16'(writes));
		if (writes) begin
			check_value("stim_rd", 16'(rec.rd), 16'(wr.rd));
			check_value("stim_data", 16'(rec.data), 16'(wr.data));
			exp_q.push_back(wr);
		end
	endtask

	// Waits until every expected write has shown up
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			fail_run($sformatf("Timed out with %0d writes still pending", exp_q.size()));
		end
	endtask

	// Outputs change on the rising edge
	// Sampled half a cycle later
	always @(negedge clk) begin
		write_t want;
		if (!rst && result_valid) begin
			if (exp_q.size() == 0) begin
				fail_run($sformatf("Result for register %0d arrived with no write pending",
					result_reg));
			end else begin
				want = exp_q.pop_front();
				check_value("result_reg", 16'(result_reg), 16'(want.rd));
				check_value("result_data", 16'(result_data), 16'(want.data));
				write_count++;
			end
		end
	end

	initial begin
		stim_rec_t rec;
		int idx;
		int r;
		bit done;

		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		write_count = 0;
		for (r = 0; r < `NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		$readmemh("bench/dp_stim.txt", stim_mem);

		// Reset for 10 cycles
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		idx = 0;
		done = 1'b0;
		while (!done) begin
			if (idx >= MAX_RECS) begin
				fail_run("Stimulus file has no end marker");
			end else begin
				rec = read_record(idx);
				if (rec.flag == END_FLAG) begin
					done = 1'b1;
				end else begin
					drive_record(rec);
					idx++;
				end
			end
		end

		@(posedge clk);
		instr_valid <= 1'b0;
		wait_drain();
		repeat (QUIET_EDGES) @(posedge clk);

		$display("Instructions: %0d, writes checked: %0d", idx, write_count);
		$display("NO ERRORS");
		$finish;
	end
endmodule

// File: bench/dp_stim.txt
// Columns: instr gap flag rd data, all hex
// instr = {op, rd, rs, imm}; gap = idle cycles before it; flag 1 = write expected, f = end

// LDI to every register, spaced out
103c 02 1 0 3c  // LDI r0, 3c
14f0 02 1 1 f0  // LDI r1, f0
1881 04 1 2 81  // LDI r2, 81
1c07 01 1 3 07  // LDI r3, 07

// ADD and SUB, with wraparound both ways
3455 03 1 1 2c  // ADD r1, r0  f0+3c wraps
3a00 03 1 2 02  // ADD r2, r2  81+81 wraps
4e00 03 1 3 05  // SUB r3, r2
4800 03 1 2 c6  // SUB r2, r0  below zero
3300 03 1 0 41  // ADD r0, r3
4f00 03 1 3 00  // SUB r3, r3
4d00 03 1 3 d4  // SUB r3, r1  below zero
37aa 03 1 1 00  // ADD r1, r3  exactly 256

// Bitwise ops and MOV
145a 03 1 1 5a  // LDI r1, 5a
5900 03 1 2 42  // AND r2, r1
6100 03 1 0 5b  // OR  r0, r1
7d00 03 1 3 8e  // XOR r3, r1
2700 03 1 1 8e  // MOV r1, r3
7500 03 1 1 00  // XOR r1, r1
6600 03 1 1 42  // OR  r1, r2
2233 03 1 0 42  // MOV r0, r2

// Dependent chain, one per cycle
1011 03 1 0 11  // LDI r0, 11
3000 00 1 0 22  // ADD r0, r0
3400 00 1 1 64  // ADD r1, r0
4100 00 1 0 be  // SUB r0, r1  below zero
7400 00 1 1 da  // XOR r1, r0
2900 00 1 2 da  // MOV r2, r1
5800 00 1 2 9a  // AND r2, r0
6e00 00 1 3 9e  // OR  r3, r2
3f00 00 1 3 3c  // ADD r3, r3  wraps
18ff 00 1 2 ff  // LDI r2, ff
3b00 00 1 2 3b  // ADD r2, r3  wraps
4600 01 1 1 9f  // SUB r1, r2  one cycle behind

// NOP and unused opcodes, then reads back
0055 02 0 0 00  // NOP
8c77 00 0 0 00  // opcode 8 naming r3
f4aa 00 0 0 00  // opcode f naming r1
9000 00 0 0 00  // opcode 9
2000 00 1 0 be  // MOV r0, r0
c5ff 00 0 0 00  // opcode c naming r1
2500 00 1 1 9f  // MOV r1, r1
0a12 01 0 0 00  // NOP naming r2
2f00 00 1 3 3c  // MOV r3, r3
2a00 03 1 2 3b  // MOV r2, r2
e8e8 00 0 0 00  // opcode e naming r2
6200 00 1 0 bf  // OR  r0, r2

// End of stream
0000 00 f 0 00

// File: list.f
+incdir+design
design/dp_pkg.sv
design/bus_switch.sv
design/instr_decode.sv
design/alu_execute.sv
design/reg_result.sv
design/dp_top.sv
bench/dp_properties.sv
bench/dp_tb.sv

// File: Makefile
# Verilator build, run and lint for the datapath testbench
# Run from the project root, the testbench reads bench/dp_stim.txt

SIM = obj_dir/Vdp_tb
SRCS = $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module dp_tb --Mdir obj_dir -o Vdp_tb

run: $(SIM)
	./$(SIM)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module dp_tb

clean:
	rm -rf obj_dir
